// ==== common/periph_pkg.sv ====
// peripheral subsystem shared definitions
// address map, bus types, register offsets and timer states

package periph_pkg;

	//////////////////////////////////////////////////////////////////////
	// address map

	localparam int NUM_TIMERS = 4;

	typedef logic [29:0] bus_addr_t;	// word address
	typedef logic [31:0] bus_data_t;
	typedef logic [3:0]  bus_bytesel_t;	// bit k enables byte k
	typedef logic [NUM_TIMERS-1:0] irq_vec_t;

	// each target block spans four words
	localparam bus_addr_t TIMER_BASE = 30'h2000_0000;
	localparam bus_addr_t IRQ_BASE   = TIMER_BASE + bus_addr_t'(4 * NUM_TIMERS);

	//////////////////////////////////////////////////////////////////////
	// register offsets and fields

	typedef logic [1:0] reg_off_t;
	typedef logic [1:0] tmr_ctrl_t;

	localparam reg_off_t REG_COUNT  = 2'd0;
	localparam reg_off_t REG_RELOAD = 2'd1;
	localparam reg_off_t REG_CTRL   = 2'd2;
	localparam reg_off_t REG_STATUS = 2'd3;

	localparam int CTRL_ENABLE   = 0;
	localparam int CTRL_PERIODIC = 1;
	localparam int STAT_EXPIRED  = 0;	// write 1 to clear

	localparam reg_off_t IRQ_PENDING = 2'd0;
	localparam reg_off_t IRQ_ENABLE  = 2'd1;
	localparam reg_off_t IRQ_RAW     = 2'd2;	// offset 3 reads zero

	//////////////////////////////////////////////////////////////////////
	// bus request / response

	typedef struct packed {
		logic         access;	// one cycle strobe
		logic         wr_en;
		bus_addr_t    addr;
		bus_bytesel_t bytesel;
		bus_data_t    wr_val;
	} bus_req_t;

	typedef struct packed {
		logic      ack;
		logic      error;
		bus_data_t data;
	} bus_rsp_t;

	typedef enum logic [1:0] {
		TMR_IDLE,
		TMR_RUN,
		TMR_DONE
	} timer_state_t;

	// byte-masked register update
	function automatic bus_data_t apply_bytesel(bus_data_t old_val, bus_data_t new_val,
						    bus_bytesel_t bytesel);
		bus_data_t merged;
		merged = old_val;
		for (int k = 0; k < 4; k++) begin
			if (bytesel[k])
				merged[k*8 +: 8] = new_val[k*8 +: 8];
		end
		return merged;
	endfunction

endpackage

// ==== hw/bus_fabric.sv ====
// request decode into per-target select strobes
// default ack + error responder for unmapped addresses, response OR-merge

module bus_fabric (
	input  logic                 clk,
	input  logic                 i_rst_n,
	input  periph_pkg::bus_req_t i_req,
	input  periph_pkg::bus_rsp_t i_timer_rsp [periph_pkg::NUM_TIMERS],
	input  periph_pkg::bus_rsp_t i_irq_rsp,
	output periph_pkg::irq_vec_t o_timer_sel,
	output logic                 o_irq_sel,
	output periph_pkg::bus_rsp_t o_rsp
);

	logic                              miss;
	logic                              dflt_ack;
	periph_pkg::bus_rsp_t              dflt_rsp;
	logic [periph_pkg::NUM_TIMERS+1:0] ack_vec;

	//////////////////////////////////////////////////////////////////////
	// decode

	always_comb begin
		for (int n = 0; n < periph_pkg::NUM_TIMERS; n++) begin
			// four words per timer, so compare above the offset bits
			o_timer_sel[n] = i_req.access &&
				(i_req.addr[29:2] == 28'(periph_pkg::TIMER_BASE[29:2] + n));
		end
	end

	assign o_irq_sel = i_req.access && (i_req.addr[29:2] == periph_pkg::IRQ_BASE[29:2]);
	assign miss      = i_req.access && !(|o_timer_sel) && !o_irq_sel;

	// unmapped addresses get ack plus error so the master never hangs
	always_ff @(posedge clk) begin
		if (!i_rst_n)
			dflt_ack <= 1'b0;
		else
			dflt_ack <= miss;
	end

	always_comb begin
		dflt_rsp.ack   = dflt_ack;
		dflt_rsp.error = dflt_ack;
		dflt_rsp.data  = '0;
	end

	//////////////////////////////////////////////////////////////////////
	// OR-merge where idle targets return zero

	always_comb begin
		o_rsp = periph_pkg::bus_rsp_t'(dflt_rsp | i_irq_rsp);
		for (int n = 0; n < periph_pkg::NUM_TIMERS; n++)
			o_rsp = periph_pkg::bus_rsp_t'(o_rsp | i_timer_rsp[n]);
	end

	always_comb begin
		ack_vec[periph_pkg::NUM_TIMERS+1] = dflt_ack;
		ack_vec[periph_pkg::NUM_TIMERS]   = i_irq_rsp.ack;
		for (int n = 0; n < periph_pkg::NUM_TIMERS; n++)
			ack_vec[n] = i_timer_rsp[n].ack;
	end

	// the OR-merge only works with a single responder
	a_one_responder: assert property (@(posedge clk) disable iff (!i_rst_n)
		$onehot0(ack_vec));

	a_ack_next_cycle: assert property (@(posedge clk) disable iff (!i_rst_n)
		i_req.access |=> o_rsp.ack);

endmodule

// ==== hw/irq_ctrl.sv ====
// interrupt controller with pending latch, enable mask and registered request
// all three registers are bus mapped

module irq_ctrl (
	input  logic                 clk,
	input  logic                 i_rst_n,
	input  logic                 i_sel,
	input  periph_pkg::bus_req_t i_req,
	input  periph_pkg::irq_vec_t i_irqs,
	output periph_pkg::bus_rsp_t o_rsp,
	output logic                 o_irq_req
);

	periph_pkg::irq_vec_t  pending;
	periph_pkg::irq_vec_t  enable;
	periph_pkg::irq_vec_t  clr_mask;
	periph_pkg::reg_off_t  offset;
	periph_pkg::bus_data_t clr_word;
	periph_pkg::bus_data_t en_word;
	periph_pkg::bus_data_t rd_mux;
	periph_pkg::bus_data_t rd_data;
	logic                  wr_hit;
	logic                  ack;

	assign offset   = i_req.addr[1:0];
	assign wr_hit   = i_sel && i_req.wr_en;
	assign clr_word = periph_pkg::apply_bytesel('0, i_req.wr_val, i_req.bytesel);
	assign clr_mask = (wr_hit && offset == periph_pkg::IRQ_PENDING) ?
			  clr_word[periph_pkg::NUM_TIMERS-1:0] : '0;
	assign en_word  = periph_pkg::apply_bytesel(periph_pkg::bus_data_t'(enable),
						    i_req.wr_val, i_req.bytesel);

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			pending   <= '0;
			enable    <= '0;
			o_irq_req <= 1'b0;
			ack       <= 1'b0;
		end else begin
			pending   <= (pending & ~clr_mask) | i_irqs;	// new pulse beats a clear
			o_irq_req <= |(pending & enable);
			ack       <= i_sel;
			if (wr_hit && offset == periph_pkg::IRQ_ENABLE)
				enable <= en_word[periph_pkg::NUM_TIMERS-1:0];
		end
	end

	always_comb begin
		case (offset)
		periph_pkg::IRQ_PENDING: rd_mux = periph_pkg::bus_data_t'(pending);
		periph_pkg::IRQ_ENABLE:  rd_mux = periph_pkg::bus_data_t'(enable);
		periph_pkg::IRQ_RAW:     rd_mux = periph_pkg::bus_data_t'(i_irqs);
		default:                 rd_mux = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (i_sel)
			rd_data <= i_req.wr_en ? '0 : rd_mux;
	end

	always_comb begin
		o_rsp.ack   = ack;
		o_rsp.error = 1'b0;
		o_rsp.data  = ack ? rd_data : '0;
	end

endmodule

// ==== hw/periph_soc.sv ====
// peripheral subsystem top level
// bus fabric, timer array and interrupt controller

module periph_soc (
	input  logic                 clk,
	input  logic                 i_rst_n,
	input  periph_pkg::bus_req_t i_req,
	output periph_pkg::bus_rsp_t o_rsp,
	output logic                 o_irq_req
);

	periph_pkg::irq_vec_t timer_sel;
	periph_pkg::irq_vec_t timer_expire;
	periph_pkg::bus_rsp_t timer_rsp [periph_pkg::NUM_TIMERS];
	periph_pkg::bus_rsp_t irq_rsp;
	logic                 irq_sel;

	bus_fabric fabric (
		.clk         (clk),
		.i_rst_n     (i_rst_n),
		.i_req       (i_req),
		.i_timer_rsp (timer_rsp),
		.i_irq_rsp   (irq_rsp),
		.o_timer_sel (timer_sel),
		.o_irq_sel   (irq_sel),
		.o_rsp       (o_rsp)
	);

	for (genvar n = 0; n < periph_pkg::NUM_TIMERS; n++) begin : g_timer
		timer_block timer (
			.clk      (clk),
			.i_rst_n  (i_rst_n),
			.i_sel    (timer_sel[n]),
			.i_req    (i_req),
			.o_rsp    (timer_rsp[n]),
			.o_expire (timer_expire[n])	// irq line n
		);
	end

	irq_ctrl irq (
		.clk       (clk),
		.i_rst_n   (i_rst_n),
		.i_sel     (irq_sel),
		.i_req     (i_req),
		.i_irqs    (timer_expire),
		.o_rsp     (irq_rsp),
		.o_irq_req (o_irq_req)
	);

endmodule

// ==== periph_soc.f ====
+incdir+verif
common/periph_pkg.sv
hw/bus_fabric.sv
timer/timer_block.sv
hw/irq_ctrl.sv
hw/periph_soc.sv
verif/tb_periph_soc.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the peripheral subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_periph_soc -f periph_soc.f \
	--Mdir obj_dir -o sim_periph_soc

./obj_dir/sim_periph_soc | tee sim.log

if grep -qx "all tests passed" sim.log; then
	echo "simulation passed"
else
	echo "simulation did not pass, see sim.log"
	exit 1
fi

// ==== timer/timer_block.sv ====
// down-counting timer with reload, control and status registers
// emits a one cycle expiry pulse when the count hits zero

module timer_block (
	input  logic                 clk,
	input  logic                 i_rst_n,
	input  logic                 i_sel,
	input  periph_pkg::bus_req_t i_req,
	output periph_pkg::bus_rsp_t o_rsp,
	output logic                 o_expire
);

	periph_pkg::timer_state_t state;
	periph_pkg::bus_data_t    count;
	periph_pkg::bus_data_t    reload;
	periph_pkg::tmr_ctrl_t    ctrl;
	periph_pkg::tmr_ctrl_t    ctrl_nxt;
	periph_pkg::bus_data_t    ctrl_word;
	periph_pkg::reg_off_t     offset;
	periph_pkg::bus_data_t    rd_mux;
	periph_pkg::bus_data_t    rd_data;
	logic                     expired;
	logic                     periodic;
	logic                     wr_hit;
	logic                     ack;

	assign offset    = i_req.addr[1:0];
	assign wr_hit    = i_sel && i_req.wr_en;
	assign ctrl_word = periph_pkg::apply_bytesel(periph_pkg::bus_data_t'(ctrl),
						     i_req.wr_val, i_req.bytesel);
	assign ctrl_nxt  = (wr_hit && offset == periph_pkg::REG_CTRL) ? ctrl_word[1:0] : ctrl;
	assign periodic  = ctrl[periph_pkg::CTRL_PERIODIC] && (reload != '0);	// zero reload acts one-shot
	assign o_expire  = (state == periph_pkg::TMR_RUN) && (count == '0);

	//////////////////////////////////////////////////////////////////////
	// state machine

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			state <= periph_pkg::TMR_IDLE;
		end else begin
			case (state)
			periph_pkg::TMR_IDLE:
				if (ctrl_nxt[periph_pkg::CTRL_ENABLE])
					state <= periph_pkg::TMR_RUN;
			periph_pkg::TMR_RUN:
				if (!ctrl_nxt[periph_pkg::CTRL_ENABLE])
					state <= periph_pkg::TMR_IDLE;
				else if (o_expire && !periodic)
					state <= periph_pkg::TMR_DONE;
			periph_pkg::TMR_DONE:
				if (!ctrl_nxt[periph_pkg::CTRL_ENABLE])
					state <= periph_pkg::TMR_IDLE;
				else if (wr_hit && offset == periph_pkg::REG_CTRL)
					state <= periph_pkg::TMR_RUN;	// rewrite of enable restarts
			default:
				state <= periph_pkg::TMR_IDLE;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// registers

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			count   <= '0;
			reload  <= '0;
			ctrl    <= '0;
			expired <= 1'b0;
			ack     <= 1'b0;
		end else begin
			ctrl <= ctrl_nxt;
			ack  <= i_sel;
			if (wr_hit && offset == periph_pkg::REG_RELOAD)
				reload <= periph_pkg::apply_bytesel(reload, i_req.wr_val, i_req.bytesel);
			if (wr_hit && offset == periph_pkg::REG_COUNT) begin
				count <= periph_pkg::apply_bytesel(count, i_req.wr_val, i_req.bytesel);
			end else if (o_expire) begin
				if (periodic)
					count <= reload;
			end else if (state == periph_pkg::TMR_RUN) begin
				count <= count - 1'b1;
			end
			if (o_expire)	// set wins over a clear in the same cycle
				expired <= 1'b1;
			else if (wr_hit && offset == periph_pkg::REG_STATUS && i_req.bytesel[0] &&
				 i_req.wr_val[periph_pkg::STAT_EXPIRED])
				expired <= 1'b0;
		end
	end

	always_comb begin
		case (offset)
		periph_pkg::REG_COUNT:  rd_mux = count;
		periph_pkg::REG_RELOAD: rd_mux = reload;
		periph_pkg::REG_CTRL:   rd_mux = periph_pkg::bus_data_t'(ctrl);
		default:                rd_mux = periph_pkg::bus_data_t'(expired);
		endcase
	end

	always_ff @(posedge clk) begin
		if (i_sel)
			rd_data <= i_req.wr_en ? '0 : rd_mux;
	end

	always_comb begin
		o_rsp.ack   = ack;
		o_rsp.error = 1'b0;
		o_rsp.data  = ack ? rd_data : '0;
	end

	a_expire_single: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_expire |=> !o_expire);

endmodule

// ==== verif/tb_bus_model.svh ====
// register model for timer RELOAD, CTRL and irq ENABLE
// bus access tasks with ack timeout and byte-masked model updates

localparam int ACK_TIMEOUT = 8;

periph_pkg::bus_data_t model_reload [periph_pkg::NUM_TIMERS];
periph_pkg::bus_data_t model_ctrl [periph_pkg::NUM_TIMERS];
periph_pkg::bus_data_t model_enable;

function automatic periph_pkg::bus_data_t merge_bytes(periph_pkg::bus_data_t old_val,
		periph_pkg::bus_data_t new_val, periph_pkg::bus_bytesel_t bytesel);
	periph_pkg::bus_data_t mask;
	mask = {{8{bytesel[3]}}, {8{bytesel[2]}}, {8{bytesel[1]}}, {8{bytesel[0]}}};
	return (old_val & ~mask) | (new_val & mask);
endfunction

function automatic periph_pkg::bus_addr_t timer_addr(int n, periph_pkg::reg_off_t off);
	return periph_pkg::TIMER_BASE + periph_pkg::bus_addr_t'(4 * n + int'(off));
endfunction

function automatic periph_pkg::bus_addr_t irq_addr(periph_pkg::reg_off_t off);
	return periph_pkg::IRQ_BASE + periph_pkg::bus_addr_t'(off);
endfunction

// random register that the model tracks
function automatic periph_pkg::bus_addr_t pick_model_reg();
	int n;
	n = $urandom_range(periph_pkg::NUM_TIMERS - 1);
	case ($urandom_range(2))
	0:       return timer_addr(n, periph_pkg::REG_RELOAD);
	1:       return timer_addr(n, periph_pkg::REG_CTRL);
	default: return irq_addr(periph_pkg::IRQ_ENABLE);
	endcase
endfunction

function automatic void model_write(periph_pkg::bus_addr_t addr,
		periph_pkg::bus_bytesel_t bytesel, periph_pkg::bus_data_t val);
	for (int n = 0; n < periph_pkg::NUM_TIMERS; n++) begin
		if (addr == timer_addr(n, periph_pkg::REG_RELOAD))
			model_reload[n] = merge_bytes(model_reload[n], val, bytesel);
		if (addr == timer_addr(n, periph_pkg::REG_CTRL))
			model_ctrl[n] = merge_bytes(model_ctrl[n], val, bytesel) & 32'h3;	// enable, periodic
	end
	if (addr == irq_addr(periph_pkg::IRQ_ENABLE))
		model_enable = merge_bytes(model_enable, val, bytesel) &
			((32'd1 << periph_pkg::NUM_TIMERS) - 32'd1);
endfunction

function automatic periph_pkg::bus_data_t model_read(periph_pkg::bus_addr_t addr);
	for (int n = 0; n < periph_pkg::NUM_TIMERS; n++) begin
		if (addr == timer_addr(n, periph_pkg::REG_RELOAD))
			return model_reload[n];
		if (addr == timer_addr(n, periph_pkg::REG_CTRL))
			return model_ctrl[n];
	end
	return model_enable;
endfunction

function automatic void report_mismatch(string name, periph_pkg::bus_data_t got,
		periph_pkg::bus_data_t exp);
	$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
	errors++;
endfunction

function automatic void check_rsp(periph_pkg::bus_rsp_t rsp, logic exp_error,
		periph_pkg::bus_data_t exp_data);
	if (rsp.error !== exp_error)
		report_mismatch("o_rsp.error", 32'(rsp.error), 32'(exp_error));
	if (rsp.data !== exp_data)
		report_mismatch("o_rsp.data", rsp.data, exp_data);
endfunction

task automatic drive_req(input logic wr, input periph_pkg::bus_addr_t addr,
		input periph_pkg::bus_bytesel_t bytesel, input periph_pkg::bus_data_t val);
	bus_req.access  = 1'b1;
	bus_req.wr_en   = wr;
	bus_req.addr    = addr;
	bus_req.bytesel = bytesel;
	bus_req.wr_val  = val;
endtask

// single strobe followed by a wait for the ack
task automatic bus_access(input periph_pkg::bus_addr_t addr, input logic wr,
		input periph_pkg::bus_bytesel_t bytesel, input periph_pkg::bus_data_t val,
		output periph_pkg::bus_rsp_t rsp);
	int lat;
	@(negedge clk);
	if (bus_rsp.ack !== 1'b0) begin
		$display("access to %h found ack already high before its strobe", addr);
		errors++;
	end
	drive_req(wr, addr, bytesel, val);
	lat = 0;
	rsp = '0;
	while (!rsp.ack && lat < ACK_TIMEOUT) begin
		@(negedge clk);
		rsp = bus_rsp;
		bus_req.access = 1'b0;
		lat++;
	end
	if (!rsp.ack) begin
		$display("access to %h got no ack within %0d cycles", addr, ACK_TIMEOUT);
		errors++;
	end else if (lat != 1) begin
		$display("access to %h was acked after %0d cycles instead of one", addr, lat);
		errors++;
	end
endtask

task automatic bus_write(input periph_pkg::bus_addr_t addr,
		input periph_pkg::bus_bytesel_t bytesel, input periph_pkg::bus_data_t val);
	periph_pkg::bus_rsp_t rsp;
	bus_access(addr, 1'b1, bytesel, val, rsp);
	check_rsp(rsp, 1'b0, '0);	// writes return zero data
	model_write(addr, bytesel, val);
endtask

task automatic bus_read(input periph_pkg::bus_addr_t addr, output periph_pkg::bus_data_t data);
	periph_pkg::bus_rsp_t rsp;
	bus_access(addr, 1'b0, 4'hf, '0, rsp);
	if (rsp.error !== 1'b0)
		report_mismatch("o_rsp.error", 32'(rsp.error), 32'h0);
	data = rsp.data;
endtask

// write strobe directly followed by a read strobe
task automatic bus_pair(input periph_pkg::bus_addr_t wr_addr,
		input periph_pkg::bus_bytesel_t bytesel, input periph_pkg::bus_data_t val,
		input periph_pkg::bus_addr_t rd_addr,
		output periph_pkg::bus_rsp_t wr_rsp, output periph_pkg::bus_rsp_t rd_rsp);
	@(negedge clk);
	drive_req(1'b1, wr_addr, bytesel, val);
	@(negedge clk);
	wr_rsp = bus_rsp;
	drive_req(1'b0, rd_addr, 4'hf, '0);
	@(negedge clk);
	rd_rsp = bus_rsp;
	bus_req.access = 1'b0;
	model_write(wr_addr, bytesel, val);
	if (!wr_rsp.ack || !rd_rsp.ack) begin
		$display("back-to-back access to %h, %h missed an ack", wr_addr, rd_addr);
		errors++;
	end
endtask

task automatic wait_irq(input logic level, input int limit);
	int cycles;
	cycles = 0;
	while (irq_req !== level && cycles < limit) begin
		@(negedge clk);
		cycles++;
	end
	if (irq_req !== level)
		report_mismatch("o_irq_req", 32'(irq_req), 32'(level));
endtask

task automatic stop_timers();
	for (int k = 0; k < periph_pkg::NUM_TIMERS; k++) begin
		bus_write(timer_addr(k, periph_pkg::REG_CTRL), 4'hf, '0);
		bus_write(timer_addr(k, periph_pkg::REG_STATUS), 4'hf, 32'h1);
	end
	bus_write(irq_addr(periph_pkg::IRQ_ENABLE), 4'hf, '0);
	bus_write(irq_addr(periph_pkg::IRQ_PENDING), 4'hf, 32'hffff_ffff);
endtask

// ==== verif/tb_periph_soc.sv ====
// testbench for the peripheral subsystem
// seeded random register, decode, timer and interrupt tests

module tb_periph_soc;

	logic                 clk;
	logic                 rst_n;
	periph_pkg::bus_req_t bus_req;
	periph_pkg::bus_rsp_t bus_rsp;
	logic                 irq_req;
	int                   errors;
	int                   mark;
	int                   test_num;

	periph_soc uut (
		.clk       (clk),
		.i_rst_n   (rst_n),
		.i_req     (bus_req),
		.o_rsp     (bus_rsp),
		.o_irq_req (irq_req)
	);

	`include "tb_bus_model.svh"

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic end_test(string name);
		test_num++;
		$display("test %0d %s: %0d errors", test_num, name, errors - mark);
		mark = errors;
	endtask

	initial begin
		periph_pkg::bus_rsp_t  rsp;
		periph_pkg::bus_rsp_t  rsp_b;
		periph_pkg::bus_addr_t addr;
		periph_pkg::bus_addr_t rd_addr;
		periph_pkg::bus_data_t rd;
		periph_pkg::bus_data_t val;
		int                    n;
		int                    tries;
		void'($urandom(32'h45330da7));
		rst_n    = 1'b0;
		bus_req  = '0;
		errors   = 0;
		mark     = 0;
		test_num = 0;
		model_enable = '0;
		for (int k = 0; k < periph_pkg::NUM_TIMERS; k++) begin
			model_reload[k] = '0;
			model_ctrl[k]   = '0;
		end
		repeat (16) @(negedge clk);
		rst_n = 1'b1;

		//////////////////////////////////////////////////////////////////////
		// bus level tests

		repeat (40) begin
			addr = pick_model_reg();
			bus_write(addr, 4'($urandom), $urandom);
			bus_read(addr, rd);
			if (rd !== model_read(addr))
				report_mismatch("o_rsp.data", rd, model_read(addr));
		end
		stop_timers();
		end_test("register readback");

		repeat (20) begin
			do
				addr = periph_pkg::bus_addr_t'($urandom);
			while (addr >= periph_pkg::TIMER_BASE && addr <= irq_addr(2'd3));
			bus_access(addr, 1'($urandom), 4'hf, $urandom, rsp);
			check_rsp(rsp, 1'b1, '0);
		end
		end_test("unmapped access");

		repeat (20) begin
			addr    = pick_model_reg();
			rd_addr = ($urandom_range(1) == 1) ? addr : pick_model_reg();	// often the same word
			bus_pair(addr, 4'($urandom), $urandom, rd_addr, rsp, rsp_b);
			check_rsp(rsp, 1'b0, '0);
			check_rsp(rsp_b, 1'b0, model_read(rd_addr));
		end
		stop_timers();
		end_test("back-to-back access");

		//////////////////////////////////////////////////////////////////////
		// timers and interrupts

		n = $urandom_range(periph_pkg::NUM_TIMERS - 1);
		bus_write(timer_addr(n, periph_pkg::REG_COUNT), 4'hf, 32'($urandom_range(20, 2)));
		bus_write(timer_addr(n, periph_pkg::REG_CTRL), 4'h1, 32'h1);	// one-shot
		tries = 0;
		rd = '0;
		while (!rd[0] && tries < 100) begin
			bus_read(timer_addr(n, periph_pkg::REG_STATUS), rd);
			tries++;
		end
		if (!rd[0]) begin
			$display("timer %0d never showed its expired status", n);
			errors++;
		end
		bus_read(irq_addr(periph_pkg::IRQ_PENDING), rd);
		if (rd !== 32'(1 << n))
			report_mismatch("o_rsp.data", rd, 32'(1 << n));
		bus_read(timer_addr(n, periph_pkg::REG_COUNT), rd);
		if (rd !== '0)
			report_mismatch("o_rsp.data", rd, '0);
		end_test("one-shot expiry");

		// pending is still set while the mask is clear
		repeat (8) begin
			@(negedge clk);
			if (irq_req !== 1'b0)
				report_mismatch("o_irq_req", 32'(irq_req), '0);
		end
		bus_write(irq_addr(periph_pkg::IRQ_ENABLE), 4'h1, 32'(1 << n));
		wait_irq(1'b1, 2);
		bus_write(irq_addr(periph_pkg::IRQ_PENDING), 4'h1, 32'(1 << n));
		wait_irq(1'b0, 2);
		stop_timers();
		end_test("interrupt masking");

		n   = $urandom_range(periph_pkg::NUM_TIMERS - 1);
		val = 32'($urandom_range(24, 4));
		bus_write(timer_addr(n, periph_pkg::REG_RELOAD), 4'hf, val);
		bus_write(timer_addr(n, periph_pkg::REG_COUNT), 4'hf, val);
		bus_write(timer_addr(n, periph_pkg::REG_CTRL), 4'h1, 32'h3);
		repeat (3) begin
			bus_write(irq_addr(periph_pkg::IRQ_PENDING), 4'hf, 32'hf);
			tries = 0;
			rd = '0;
			while (!rd[n] && tries < 100) begin
				bus_read(timer_addr(n, periph_pkg::REG_COUNT), rd);
				if (rd > model_reload[n]) begin
					$display("CHECK FAILED o_rsp.data: count %h above reload %h",
						 rd, model_reload[n]);
					errors++;
				end
				bus_read(irq_addr(periph_pkg::IRQ_PENDING), rd);
				tries++;
			end
			if (!rd[n]) begin
				$display("periodic timer %0d did not set pending again", n);
				errors++;
			end
		end
		stop_timers();
		end_test("periodic mode");

		$display("%0d tests run, %0d errors", test_num, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule
